//--- hdl/dc_ctrl_pkg.sv
package dc_ctrl_pkg;

    //////////////////////////////////////////////////
    // widths and timing constants

    localparam int count_width = 16;
    localparam int num_counters = 3;

    // hold time of a reset output in control_clock cycles
    localparam int reset_hold_cycles = 64;
    localparam int hold_cnt_width = $clog2(reset_hold_cycles);
    localparam logic [hold_cnt_width-1:0] hold_load = hold_cnt_width'(reset_hold_cycles - 1);

    // led counter taps
    localparam int glow_slow_bit = 9;
    localparam int glow_fast_bit = 6;
    localparam int blink_bit = 8;
    localparam int led_cnt_width = glow_slow_bit + 1;

    //////////////////////////////////////////////////
    // host command set

    typedef enum logic [2:0] {
        op_nop           = 3'd0,
        op_reset_console = 3'd1,
        op_reset_opt     = 3'd2,
        op_set_led_mode  = 3'd3,
        op_read_count    = 3'd4,
        op_clear_counts  = 3'd5
    } cmd_op_t;

    typedef enum logic [1:0] {
        led_status         = 2'd0,
        led_follow_opt     = 2'd1,
        led_follow_console = 2'd2,
        led_off            = 2'd3
    } led_mode_t;

    typedef enum logic [1:0] {
        cnt_pll54_loss = 2'd0,
        cnt_hdmi_loss  = 2'd1,
        cnt_resync     = 2'd2
    } count_sel_t;

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_exec      = 2'd1,
        st_ack       = 2'd2,
        st_wait_drop = 2'd3
    } cmd_state_t;

endpackage

//--- hdl/supervisor_if.sv
interface supervisor_if;

    // from the command controller
    logic console_start;
    logic opt_start;
    logic clear_counts;
    dc_ctrl_pkg::led_mode_t led_mode;
    dc_ctrl_pkg::count_sel_t count_sel;

    // back from the datapath
    logic [dc_ctrl_pkg::count_width-1:0] count_value;
    logic console_active;
    logic opt_active;

    modport ctrl (
        output console_start, opt_start, clear_counts, led_mode, count_sel,
        input  count_value
    );

    modport monitor (input clear_counts, count_sel, output count_value);

    modport reset_ch (input console_start, opt_start, output console_active, opt_active);

    modport led (input led_mode, console_active, opt_active);

endinterface

//--- hdl/dc_command_ctrl.sv
module dc_command_ctrl (
    input  logic                                control_clock,
    input  logic                                reset_dc,
    input  logic                                cmd_req,
    input  dc_ctrl_pkg::cmd_op_t                cmd_op,
    input  logic [7:0]                          cmd_arg,
    output logic                                cmd_ack,
    output logic [dc_ctrl_pkg::count_width-1:0] rsp_data,
    supervisor_if.ctrl                          bus
);

    dc_ctrl_pkg::cmd_state_t state;
    logic req_q;

    // counter select comes straight from the argument byte
    assign bus.count_sel = dc_ctrl_pkg::count_sel_t'(cmd_arg[1:0]);

    //////////////////////////////////////////////////
    // handshake FSM

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            state             <= dc_ctrl_pkg::st_idle;
            req_q             <= 1'b0;
            cmd_ack           <= 1'b0;
            bus.console_start <= 1'b0;
            bus.opt_start     <= 1'b0;
            bus.clear_counts  <= 1'b0;
            bus.led_mode      <= dc_ctrl_pkg::led_status;
        end else begin
            req_q <= cmd_req;

            // ack follows the state one cycle late
            cmd_ack <= (state == dc_ctrl_pkg::st_ack) ||
                       (state == dc_ctrl_pkg::st_wait_drop);

            // pulses last one cycle only
            bus.console_start <= 1'b0;
            bus.opt_start     <= 1'b0;
            bus.clear_counts  <= 1'b0;

            case (state)
                dc_ctrl_pkg::st_idle: begin
                    if (req_q) begin
                        state <= dc_ctrl_pkg::st_exec;
                    end
                end
                dc_ctrl_pkg::st_exec: begin
                    state <= dc_ctrl_pkg::st_ack;
                    case (cmd_op)
                        dc_ctrl_pkg::op_reset_console: begin
                            bus.console_start <= 1'b1;
                        end
                        dc_ctrl_pkg::op_reset_opt: begin
                            bus.opt_start <= 1'b1;
                        end
                        dc_ctrl_pkg::op_set_led_mode: begin
                            bus.led_mode <= dc_ctrl_pkg::led_mode_t'(cmd_arg[1:0]);
                        end
                        dc_ctrl_pkg::op_clear_counts: begin
                            bus.clear_counts <= 1'b1;
                        end
                        // nop and read only acknowledge here
                        default: begin
                        end
                    endcase
                end
                dc_ctrl_pkg::st_ack: begin
                    state <= dc_ctrl_pkg::st_wait_drop;
                end
                dc_ctrl_pkg::st_wait_drop: begin
                    if (!req_q) begin
                        state <= dc_ctrl_pkg::st_idle;
                    end
                end
                default: begin
                    state <= dc_ctrl_pkg::st_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // read response, stable before ack rises

    always_ff @(posedge control_clock) begin
        if ((state == dc_ctrl_pkg::st_exec) && (cmd_op == dc_ctrl_pkg::op_read_count)) begin
            rsp_data <= bus.count_value;
        end
    end

endmodule

//--- hdl/reset_hold_gen.sv
module reset_hold_gen #(
    parameter bit is_console = 1'b0
) (
    input  logic           control_clock,
    input  logic           reset_dc,
    supervisor_if.reset_ch bus
);

    logic start;
    logic active;
    logic [dc_ctrl_pkg::hold_cnt_width-1:0] hold_cnt;

    assign start = is_console ? bus.console_start : bus.opt_start;

    // console channel also holds after power-on reset
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            active   <= is_console;
            hold_cnt <= is_console ? dc_ctrl_pkg::hold_load : '0;
        end else if (start) begin
            active   <= 1'b1;
            hold_cnt <= dc_ctrl_pkg::hold_load;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end else begin
            active <= 1'b0;
        end
    end

    generate
        if (is_console) begin : g_console
            assign bus.console_active = active;
        end else begin : g_opt
            assign bus.opt_active = active;
        end
    endgenerate

endmodule

//--- hdl/lock_event_monitor.sv
module lock_event_monitor (
    input  logic          control_clock,
    input  logic          reset_dc,
    input  logic          pll54_locked,
    input  logic          pll_hdmi_locked,
    input  logic          resync_flag,
    output logic          pll_hdmi_good,
    output logic          resync_active,
    supervisor_if.monitor bus
);

    logic [2:0] async_in;
    logic [2:0] sync_meta;
    logic [2:0] sync_q;
    logic [2:0] sync_prev;
    logic [dc_ctrl_pkg::num_counters-1:0] events;
    logic [dc_ctrl_pkg::count_width-1:0] counts [dc_ctrl_pkg::num_counters];

    // bit order matches count_sel_t
    assign async_in = {resync_flag, pll_hdmi_locked, pll54_locked};

    //////////////////////////////////////////////////
    // two-flop synchronizers plus edge history

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            sync_meta <= '0;
            sync_q    <= '0;
            sync_prev <= '0;
        end else begin
            sync_meta <= async_in;
            sync_q    <= sync_meta;
            sync_prev <= sync_q;
        end
    end

    // lock loss on falling lock, resync on rising flag
    assign events[0] = sync_prev[0] & ~sync_q[0];
    assign events[1] = sync_prev[1] & ~sync_q[1];
    assign events[2] = ~sync_prev[2] & sync_q[2];

    assign pll_hdmi_good = sync_q[1];
    assign resync_active = sync_q[2];

    //////////////////////////////////////////////////
    // saturating event counters

    always_ff @(posedge control_clock) begin
        if (reset_dc || bus.clear_counts) begin
            for (int i = 0; i < dc_ctrl_pkg::num_counters; i++) begin
                counts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < dc_ctrl_pkg::num_counters; i++) begin
                if (events[i] && (counts[i] != '1)) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (bus.count_sel)
            dc_ctrl_pkg::cnt_pll54_loss: bus.count_value = counts[0];
            dc_ctrl_pkg::cnt_hdmi_loss:  bus.count_value = counts[1];
            dc_ctrl_pkg::cnt_resync:     bus.count_value = counts[2];
            default:                     bus.count_value = '0;
        endcase
    end

endmodule

//--- hdl/status_led_driver.sv
module status_led_driver (
    input  logic      control_clock,
    input  logic      reset_dc,
    input  logic      pll_hdmi_good,
    input  logic      resync_active,
    input  logic      hdmi_ready,
    supervisor_if.led bus,
    output logic      status_led_out,
    output logic      status_led_oe
);

    logic [dc_ctrl_pkg::led_cnt_width-1:0] led_cnt;
    logic slow_on;
    logic fast_on;
    logic dim_on;
    logic blink_on;

    // triangle glow: level ramps up then down, compared with a 3-bit phase
    function automatic logic tri_glow(
        input logic [dc_ctrl_pkg::led_cnt_width-1:0] cnt,
        input int unsigned                           pos
    );
        logic [2:0] level;
        level = cnt[pos-1 -: 3];
        if (!cnt[pos]) begin
            level = ~level;
        end
        return level > cnt[2:0];
    endfunction

    assign slow_on  = tri_glow(led_cnt, dc_ctrl_pkg::glow_slow_bit);
    assign fast_on  = tri_glow(led_cnt, dc_ctrl_pkg::glow_fast_bit);
    // one cycle in eight
    assign dim_on   = (led_cnt[2:0] == 3'd0);
    assign blink_on = fast_on & led_cnt[dc_ctrl_pkg::blink_bit];

    //////////////////////////////////////////////////
    // mode mux, LED lit when driven low

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            led_cnt        <= '0;
            status_led_out <= 1'b1;
            status_led_oe  <= 1'b0;
        end else begin
            led_cnt <= led_cnt + 1'b1;
            case (bus.led_mode)
                dc_ctrl_pkg::led_status: begin
                    status_led_oe <= 1'b1;
                    if (!pll_hdmi_good) begin
                        status_led_out <= ~dim_on;
                    end else if (resync_active) begin
                        status_led_out <= ~blink_on;
                    end else if (hdmi_ready) begin
                        status_led_out <= 1'b0;
                    end else begin
                        status_led_out <= ~slow_on;
                    end
                end
                dc_ctrl_pkg::led_follow_opt: begin
                    status_led_oe  <= bus.opt_active;
                    status_led_out <= ~bus.opt_active;
                end
                dc_ctrl_pkg::led_follow_console: begin
                    status_led_oe  <= bus.console_active;
                    status_led_out <= ~bus.console_active;
                end
                default: begin
                    // released
                    status_led_oe  <= 1'b0;
                    status_led_out <= 1'b1;
                end
            endcase
        end
    end

endmodule

//--- hdl/dc_supervisor_top.sv
module dc_supervisor_top (
    input  logic                                control_clock,
    input  logic                                reset_dc,

    // host command port
    input  logic                                cmd_req,
    input  dc_ctrl_pkg::cmd_op_t                cmd_op,
    input  logic [7:0]                          cmd_arg,
    output logic                                cmd_ack,
    output logic [dc_ctrl_pkg::count_width-1:0] rsp_data,

    // async status from the video side
    input  logic                                pll54_locked,
    input  logic                                pll_hdmi_locked,
    input  logic                                resync_flag,
    input  logic                                hdmi_ready,

    // open-drain pins, oe high pulls low
    output logic                                console_nreset_oe,
    output logic                                opt_nreset_oe,
    output logic                                status_led_out,
    output logic                                status_led_oe
);

    logic pll_hdmi_good;
    logic resync_active;

    supervisor_if sup_bus ();

    dc_command_ctrl i_dc_command_ctrl (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .cmd_req       (cmd_req),
        .cmd_op        (cmd_op),
        .cmd_arg       (cmd_arg),
        .cmd_ack       (cmd_ack),
        .rsp_data      (rsp_data),
        .bus           (sup_bus.ctrl)
    );

    //////////////////////////////////////////////////
    // reset channels

    reset_hold_gen #(.is_console(1'b1)) i_console_reset (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .bus           (sup_bus.reset_ch)
    );

    reset_hold_gen #(.is_console(1'b0)) i_opt_reset (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .bus           (sup_bus.reset_ch)
    );

    assign console_nreset_oe = sup_bus.console_active;
    assign opt_nreset_oe     = sup_bus.opt_active;

    lock_event_monitor i_lock_event_monitor (
        .control_clock   (control_clock),
        .reset_dc        (reset_dc),
        .pll54_locked    (pll54_locked),
        .pll_hdmi_locked (pll_hdmi_locked),
        .resync_flag     (resync_flag),
        .pll_hdmi_good   (pll_hdmi_good),
        .resync_active   (resync_active),
        .bus             (sup_bus.monitor)
    );

    status_led_driver i_status_led_driver (
        .control_clock  (control_clock),
        .reset_dc       (reset_dc),
        .pll_hdmi_good  (pll_hdmi_good),
        .resync_active  (resync_active),
        .hdmi_ready     (hdmi_ready),
        .bus            (sup_bus.led),
        .status_led_out (status_led_out),
        .status_led_oe  (status_led_oe)
    );

endmodule

//--- verif/dc_supervisor_checker.sv
module dc_supervisor_checker (
    input  logic                                control_clock,
    input  logic                                reset_dc,
    input  logic                                cmd_req,
    input  logic                                cmd_ack,
    input  logic [dc_ctrl_pkg::count_width-1:0] rsp_data,
    input  logic                                console_nreset_oe,
    input  logic                                opt_nreset_oe,
    input  logic                                status_led_out,
    input  logic                                status_led_oe,
    input  logic                                check_strobe,
    input  int                                  row_idx,
    input  logic [4:0]                          chk_mask,
    input  logic [dc_ctrl_pkg::count_width-1:0] exp_rsp,
    input  logic [3:0]                          exp_lvl,
    input  logic                                report_now,
    output int                                  fail_count
);

    int fails = 0;
    int pass_count = 0;
    int hs_wait = 0;
    int row_bad = 0;
    int hold_len [2] = '{0, 0};
    bit req_prev = 1'b0;
    bit ack_prev = 1'b0;
    bit strobe_prev = 1'b0;
    logic [dc_ctrl_pkg::count_width-1:0] rsp_seen = '0;
    logic [3:0] got_lvl;
    string lvl_name [4] = '{"status_led_out", "status_led_oe", "opt_nreset_oe",
                            "console_nreset_oe"};
    string hold_name [2] = '{"console_nreset_oe", "opt_nreset_oe"};

    assign got_lvl    = {console_nreset_oe, opt_nreset_oe, status_led_oe, status_led_out};
    assign fail_count = fails;

    task automatic compare_value(input string label, input string name,
                                 input logic [31:0] got, input logic [31:0] exp,
                                 inout int bad);
        if (got !== exp) begin
            $display("ERR %s %s: got 0x%0h, expected 0x%0h", label, name, got, exp);
            bad++;
        end
    endtask

    task automatic close_test(input string label, input int bad);
        if (bad == 0) begin
            pass_count++;
            $display("%s: ok", label);
        end else begin
            fails++;
            $display("%s: mismatch", label);
        end
    endtask

    //////////////////////////////////////////////////
    // all sampling happens at the rising edge before the DUT updates

    always @(posedge control_clock) begin
        int bad;
        if (cmd_ack) begin
            rsp_seen = rsp_data;
        end
        if (!reset_dc) begin
            if (cmd_ack && !ack_prev && !req_prev) begin
                $display("handshake error: cmd_ack rose while cmd_req was low");
                fails++;
            end
            if (!cmd_ack && ack_prev && req_prev) begin
                $display("handshake error: cmd_ack fell while cmd_req was still high");
                fails++;
            end
            hs_wait = (cmd_req != cmd_ack) ? hs_wait + 1 : 0;
            if (hs_wait == 12) begin
                $display("handshake stalled: cmd_ack did not follow cmd_req in 12 cycles");
                fails++;
            end
        end
        // hold widths of the console after reset and of both after a start
        for (int c = 0; c < 2; c++) begin
            if (reset_dc) begin
                hold_len[c] = 0;
            end else if (got_lvl[3-c]) begin
                hold_len[c]++;
            end else if (hold_len[c] != 0) begin
                bad = 0;
                compare_value("hold", hold_name[c], hold_len[c],
                              dc_ctrl_pkg::reset_hold_cycles, bad);
                close_test($sformatf("hold %s %0d cycles", hold_name[c], hold_len[c]), bad);
                hold_len[c] = 0;
            end
        end
        // levels are compared on every cycle of the strobe window
        if (check_strobe) begin
            if (chk_mask[4] && !strobe_prev) begin
                compare_value($sformatf("row %0d", row_idx), "rsp_data", rsp_seen, exp_rsp,
                              row_bad);
            end
            for (int i = 0; i < 4; i++) begin
                if (chk_mask[i]) begin
                    compare_value($sformatf("row %0d", row_idx), lvl_name[i], got_lvl[i],
                                  exp_lvl[i], row_bad);
                end
            end
        end else if (strobe_prev) begin
            close_test($sformatf("row %0d", row_idx), row_bad);
            row_bad = 0;
        end
        if (report_now) begin
            $display("summary: %0d passed, %0d failed", pass_count, fails);
        end
        req_prev    = cmd_req;
        ack_prev    = cmd_ack;
        strobe_prev = check_strobe;
    end

endmodule

//--- include/dc_tb_vectors.svh
`ifndef DC_TB_VECTORS_SVH
`define DC_TB_VECTORS_SVH

typedef struct packed {
    logic [3:0]                          levels;
    logic [1:0]                          pulse_sel;
    dc_ctrl_pkg::cmd_op_t                op;
    logic [7:0]                          arg;
    logic [7:0]                          settle;
    logic [4:0]                          chk;
    logic [dc_ctrl_pkg::count_width-1:0] exp_rsp;
    logic [3:0]                          exp_lvl;
} vec_row_t;

localparam int num_rows = 16;

// levels {pll54, hdmi lock, resync, hdmi_ready}, pulse input (1 pll54, 2 hdmi, 3 resync),
// op, arg, settle cycles, check mask {rsp, console, opt, led_oe, led_out},
// expected rsp before pulses are added, expected {console, opt, led_oe, led_out}
localparam vec_row_t vectors [num_rows] = '{
    '{4'b1100, 2'd0, dc_ctrl_pkg::op_nop,            8'd0, 8'd0,  5'b01100, 16'd0, 4'b1000},
    '{4'b1100, 2'd0, dc_ctrl_pkg::op_set_led_mode,   8'd3, 8'd0,  5'b00010, 16'd0, 4'b0000},
    '{4'b1100, 2'd0, dc_ctrl_pkg::op_set_led_mode,   8'd1, 8'd0,  5'b00011, 16'd0, 4'b0001},
    '{4'b1100, 2'd0, dc_ctrl_pkg::op_reset_opt,      8'd0, 8'd0,  5'b00111, 16'd0, 4'b0110},
    '{4'b1101, 2'd0, dc_ctrl_pkg::op_set_led_mode,   8'd0, 8'd3,  5'b00011, 16'd0, 4'b0010},
    '{4'b1101, 2'd0, dc_ctrl_pkg::op_nop,            8'd0, 8'd80, 5'b01100, 16'd0, 4'b0000},
    '{4'b1101, 2'd0, dc_ctrl_pkg::op_reset_console,  8'd0, 8'd0,  5'b01100, 16'd0, 4'b1000},
    '{4'b1101, 2'd0, dc_ctrl_pkg::op_nop,            8'd0, 8'd80, 5'b01100, 16'd0, 4'b0000},
    // counters start from zero here
    '{4'b1101, 2'd1, dc_ctrl_pkg::op_read_count,     8'd0, 8'd0,  5'b10000, 16'd0, 4'b0000},
    '{4'b1101, 2'd2, dc_ctrl_pkg::op_read_count,     8'd1, 8'd0,  5'b10000, 16'd0, 4'b0000},
    '{4'b1101, 2'd3, dc_ctrl_pkg::op_read_count,     8'd2, 8'd0,  5'b10000, 16'd0, 4'b0000},
    '{4'b1101, 2'd0, dc_ctrl_pkg::op_clear_counts,   8'd0, 8'd0,  5'b00011, 16'd0, 4'b0010},
    '{4'b1101, 2'd0, dc_ctrl_pkg::op_read_count,     8'd0, 8'd0,  5'b10000, 16'd0, 4'b0000},
    '{4'b1101, 2'd0, dc_ctrl_pkg::op_read_count,     8'd1, 8'd0,  5'b10000, 16'd0, 4'b0000},
    '{4'b1101, 2'd0, dc_ctrl_pkg::op_read_count,     8'd2, 8'd0,  5'b10000, 16'd0, 4'b0000},
    '{4'b1101, 2'd0, dc_ctrl_pkg::op_set_led_mode,   8'd2, 8'd0,  5'b00011, 16'd0, 4'b0001}
};

`endif

//--- verif/dc_supervisor_tb.sv
module dc_supervisor_tb;

    `include "dc_tb_vectors.svh"

    localparam int watchdog_cycles = num_rows * (2 * dc_ctrl_pkg::reset_hold_cycles + 50);
    // one full period of the 3-bit PWM phase
    localparam int check_cycles = 8;

    logic control_clock;
    logic reset_dc;
    logic cmd_req;
    dc_ctrl_pkg::cmd_op_t cmd_op;
    logic [7:0] cmd_arg;
    logic cmd_ack;
    logic [dc_ctrl_pkg::count_width-1:0] rsp_data;
    logic pll54_locked;
    logic pll_hdmi_locked;
    logic resync_flag;
    logic hdmi_ready;
    logic console_nreset_oe;
    logic opt_nreset_oe;
    logic status_led_out;
    logic status_led_oe;

    // expectations handed to the checker
    logic check_strobe;
    logic report_now;
    int row_idx;
    logic [4:0] chk_mask;
    logic [dc_ctrl_pkg::count_width-1:0] exp_rsp;
    logic [3:0] exp_lvl;
    int fail_count;
    logic [31:0] lcg_state;

    dc_supervisor_top i_dc_supervisor_top (.*);

    dc_supervisor_checker i_checker (.*);

    always #5 control_clock = ~control_clock;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // full four-phase exchange that starts and ends on a falling edge
    task automatic run_handshake(input dc_ctrl_pkg::cmd_op_t op, input logic [7:0] arg);
        int waited;
        cmd_op  = op;
        cmd_arg = arg;
        cmd_req = 1'b1;
        waited  = 0;
        while (cmd_ack !== 1'b1 && waited < 16) begin
            @(negedge control_clock);
            waited++;
        end
        cmd_req = 1'b0;
        waited  = 0;
        while (cmd_ack !== 1'b0 && waited < 16) begin
            @(negedge control_clock);
            waited++;
        end
    endtask

    // each pulse leaves the idle level for 6 cycles and then rests 6
    task automatic pulse_input(input logic [1:0] sel, input int count);
        for (int i = 0; i < count; i++) begin
            repeat (2) begin
                case (sel)
                    2'd1: pll54_locked = ~pll54_locked;
                    2'd2: pll_hdmi_locked = ~pll_hdmi_locked;
                    default: resync_flag = ~resync_flag;
                endcase
                repeat (6) @(negedge control_clock);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // table-driven stimulus

    initial begin
        int pulses;
        control_clock = 1'b0;
        reset_dc      = 1'b1;
        cmd_req       = 1'b0;
        cmd_op        = dc_ctrl_pkg::op_nop;
        cmd_arg       = 8'd0;
        {pll54_locked, pll_hdmi_locked, resync_flag, hdmi_ready} = 4'b1100;
        check_strobe  = 1'b0;
        report_now    = 1'b0;
        row_idx       = 0;
        chk_mask      = '0;
        exp_rsp       = '0;
        exp_lvl       = '0;
        lcg_state     = 32'h13fd_6043;
        repeat (8) @(negedge control_clock);
        reset_dc = 1'b0;

        for (int r = 0; r < num_rows; r++) begin
            {pll54_locked, pll_hdmi_locked, resync_flag, hdmi_ready} = vectors[r].levels;
            pulses = 0;
            if (vectors[r].pulse_sel != 2'd0) begin
                lcg_state = next_random(lcg_state);
                pulses    = int'(lcg_state[23:16] % 8'd7) + 1;
                pulse_input(vectors[r].pulse_sel, pulses);
            end
            run_handshake(vectors[r].op, vectors[r].arg);
            repeat (vectors[r].settle) @(negedge control_clock);
            row_idx      = r;
            chk_mask     = vectors[r].chk;
            exp_rsp      = vectors[r].exp_rsp + 16'(pulses);
            exp_lvl      = vectors[r].exp_lvl;
            // levels must stay steady over the whole window
            check_strobe = 1'b1;
            repeat (check_cycles) @(negedge control_clock);
            check_strobe = 1'b0;
        end

        // let both hold pulses end so their widths get checked
        while (console_nreset_oe || opt_nreset_oe) begin
            @(negedge control_clock);
        end
        report_now = 1'b1;
        @(negedge control_clock);
        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge control_clock);
        $display("watchdog expired: run did not finish within %0d cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
hdl/dc_ctrl_pkg.sv
hdl/supervisor_if.sv
hdl/dc_command_ctrl.sv
hdl/reset_hold_gen.sv
hdl/lock_event_monitor.sv
hdl/status_led_driver.sv
hdl/dc_supervisor_top.sv
verif/dc_supervisor_checker.sv
verif/dc_supervisor_tb.sv
